//--- bench/tb_tasks.svh
////////////////////
// Wishbone host
////////////////////

// One classic cycle where ok stays low if no ack came within limit cycles
task automatic wb_access(input logic we, input logic [wb_adr_w-1:0] adr,
                         input logic [wb_dat_w-1:0] wdat, input int limit,
                         output logic [wb_dat_w-1:0] rdat, output logic ok);
    int n;
    n    = 0;
    ok   = 1'b0;
    rdat = '0;
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    while (!ok && n < limit) begin
        @(negedge clk);
        n++;
        if (wb_rsp.ack) begin
            ok   = 1'b1;
            rdat = wb_rsp.dat;
        end
    end
    wb_req = '0;
endtask

task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %s", msg);
endtask

task automatic write_symbol(input sym_t s, input int limit, output logic ok);
    logic [wb_dat_w-1:0] d;
    wb_access(1'b1, adr_symbol, wb_dat_w'(s), limit, d, ok);
endtask

task automatic read_result(output logic valid, output logic b);
    logic [wb_dat_w-1:0] d;
    logic                ok;
    wb_access(1'b0, adr_result, '0, 10, d, ok);
    if (!ok) report_error("no ack on result read");
    valid = d[1];
    b     = d[0];
endtask

task automatic read_status(output logic [count_w-1:0] cnt, output logic busy);
    logic [wb_dat_w-1:0] d;
    logic                ok;
    wb_access(1'b0, adr_status, '0, 10, d, ok);
    if (!ok) report_error("no ack on status read");
    cnt  = d[count_w-1:0];
    busy = d[wb_dat_w-1];
endtask

task automatic clear_decoder();
    logic [wb_dat_w-1:0] d;
    logic                ok;
    wb_access(1'b1, adr_clear, '0, 10, d, ok);
    if (!ok) report_error("no ack on clear write");
endtask

task automatic wait_idle();
    logic [count_w-1:0] cnt;
    logic               busy;
    int                 tries;
    tries = 0;
    busy  = 1'b1;
    while (busy && tries < 40) begin
        read_status(cnt, busy);
        tries++;
    end
    if (busy) report_error("timeout waiting for the decoder to go idle");
endtask

////////////////////
// Compare tasks
////////////////////

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s: expected %0b, actual %0b", name, exp, act);
    end
endtask

task automatic check_count(input string name, input logic [count_w-1:0] exp,
                           input logic [count_w-1:0] act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic check_num(input string name, input int exp, input int act);
    if (act != exp) begin
        errors++;
        $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

////////////////////
// Directed tests
////////////////////

// Read out everything waiting and check each bit against the encoder input
task automatic drain_results(input string name);
    logic valid;
    logic b;
    int   guard;
    guard = 0;
    valid = 1'b1;
    while (valid && guard <= fifo_depth) begin
        read_result(valid, b);
        if (valid) begin
            if (out_idx < data_bits.size()) begin
                check_bit($sformatf("%s bit %0d", name, out_idx), data_bits[out_idx], b);
            end
            out_idx++;
        end
        guard++;
    end
endtask

task automatic run_stream(input string name, input int n_syms, input int err_every);
    logic ok;
    encode_stream(n_syms, err_every);
    out_idx = 0;
    for (int i = 0; i < n_syms; i++) begin
        write_symbol(tx_syms[i], 100, ok);
        if (!ok) report_error($sformatf("%s: symbol %0d write got no ack", name, i));
        wait_idle();
        drain_results(name);
    end
    check_num({name, " output count"}, n_syms - trace_depth, out_idx);
endtask

task automatic reset_state();
    logic [count_w-1:0] cnt;
    logic               busy;
    logic               valid;
    logic               b;
    read_status(cnt, busy);
    check_count("reset count", '0, cnt);
    check_bit("reset busy", 1'b0, busy);
    read_result(valid, b);
    check_bit("reset result valid", 1'b0, valid);
    check_bit("reset result bit", 1'b0, b);
endtask

task automatic clean_stream();
    clear_decoder();
    run_stream("clean", 40, 0);
endtask

task automatic noisy_stream();
    clear_decoder();
    run_stream("noisy", 40, 12);
endtask

task automatic fifo_backpressure();
    logic [count_w-1:0] cnt;
    logic               busy;
    logic               ok;
    logic               valid;
    logic               b;
    clear_decoder();
    encode_stream(32, 0);
    out_idx = 0;
    // Fill the FIFO without reading
    for (int i = 0; i < 31; i++) begin
        write_symbol(tx_syms[i], 100, ok);
        if (!ok) report_error($sformatf("fill: symbol %0d write got no ack", i));
        wait_idle();
    end
    read_status(cnt, busy);
    check_count("full count", count_w'(fifo_depth), cnt);
    write_symbol(tx_syms[31], 40, ok);
    if (ok) report_error("symbol write was acked while the FIFO was full");
    read_result(valid, b);
    check_bit("first result valid", 1'b1, valid);
    check_bit("bp bit 0", data_bits[0], b);
    out_idx = 1;
    write_symbol(tx_syms[31], 100, ok);
    if (!ok) report_error("symbol write got no ack after a result was read");
    wait_idle();
    drain_results("bp");
    check_num("bp output count", 32 - trace_depth, out_idx);
endtask

task automatic clear_restart();
    logic [count_w-1:0] cnt;
    logic               busy;
    logic               ok;
    clear_decoder();
    encode_stream(20, 0);
    // Partial stream leaves a few bits in the FIFO
    for (int i = 0; i < 20; i++) begin
        write_symbol(tx_syms[i], 100, ok);
        if (!ok) report_error($sformatf("partial: symbol %0d write got no ack", i));
        wait_idle();
    end
    read_status(cnt, busy);
    check_count("count before clear", count_w'(20 - trace_depth), cnt);
    clear_decoder();
    read_status(cnt, busy);
    check_count("count after clear", '0, cnt);
    check_bit("busy after clear", 1'b0, busy);
    run_stream("restart", 40, 0);
endtask

//--- bench/tb_viterbi.sv
module tb_viterbi;
    timeunit 1ns;
    timeprecision 1ps;

    import viterbi_pkg::*;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    int   errors;
    int   n_tests;
    int   n_failed;
    int   out_idx;
    int   errs_before;
    logic data_bits [$];
    sym_t tx_syms   [$];

    viterbi_top dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #10 clk = ~clk;

    ////////////////////
    // Reference encoder
    ////////////////////

    // Encoder state holds the last two inputs, newest in bit 1
    task automatic encode_stream(input int n, input int err_every);
        logic [1:0] st;
        logic       b;
        logic       g7;
        logic       g5;
        sym_t       s;
        data_bits.delete();
        tx_syms.delete();
        st = 2'b00;
        for (int i = 0; i < n; i++) begin
            b  = 1'($urandom);
            g7 = b ^ st[1] ^ st[0];
            g5 = b ^ st[0];
            s  = {g7, g5};
            // Channel error on every err_every-th symbol, alternating code bit
            if (err_every > 0 && (i % err_every) == err_every - 1) begin
                if (((i / err_every) % 2) == 0) begin
                    s[0] = ~s[0];
                end else begin
                    s[1] = ~s[1];
                end
            end
            data_bits.push_back(b);
            tx_syms.push_back(s);
            st = {b, st[1]};
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        n_tests++;
        if (errors == errs_at_start) begin
            $display("%s: ok", name);
        end else begin
            n_failed++;
            $display("%s: failed with %0d errors", name, errors - errs_at_start);
        end
    endtask

    `include "tb_tasks.svh"

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_req   = '0;
        errors   = 0;
        n_tests  = 0;
        n_failed = 0;
        out_idx  = 0;
        void'($urandom(32'h1ed9));

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs_before = errors;
        reset_state();
        finish_test("reset state", errs_before);

        errs_before = errors;
        clean_stream();
        finish_test("clean stream", errs_before);

        errs_before = errors;
        noisy_stream();
        finish_test("error correction", errs_before);

        errs_before = errors;
        fifo_backpressure();
        finish_test("back-pressure", errs_before);

        errs_before = errors;
        clear_restart();
        finish_test("clear and restart", errs_before);

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- common/viterbi_pkg.sv
package viterbi_pkg;

    ////////////////////
    // Code and trellis
    ////////////////////

    // Rate 1/2, K=3, generators 7 and 5 octal
    localparam int num_states  = 4;
    localparam int state_w     = 2;
    localparam int trace_depth = 15;
    localparam int mem_depth   = 16;
    localparam int mem_ptr_w   = $clog2(mem_depth);
    localparam int fill_w      = $clog2(trace_depth + 2);

    // Path metrics
    localparam int metric_w    = 6;
    localparam int init_metric = 16;

    // Decoded-bit FIFO
    localparam int fifo_depth = 16;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int count_w    = fifo_ptr_w + 1;

    ////////////////////
    // Host port
    ////////////////////

    localparam int wb_adr_w = 2;
    localparam int wb_dat_w = 8;

    localparam logic [wb_adr_w-1:0] adr_symbol = 2'd0;
    localparam logic [wb_adr_w-1:0] adr_result = 2'd1;
    localparam logic [wb_adr_w-1:0] adr_status = 2'd2;
    localparam logic [wb_adr_w-1:0] adr_clear  = 2'd3;

    typedef logic [1:0]            sym_t;
    typedef logic [metric_w-1:0]   metric_t;
    typedef logic [num_states-1:0] decision_t;

    // Expected code output, indexed [state][input bit]
    // State holds the last two inputs, newest in the MSB
    localparam sym_t branch_out [num_states][2] = '{
        '{2'b00, 2'b11},
        '{2'b11, 2'b00},
        '{2'b10, 2'b01},
        '{2'b01, 2'b10}
    };

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [wb_adr_w-1:0] adr;
        logic [wb_dat_w-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [wb_dat_w-1:0] dat;
    } wb_rsp_t;

    // One trellis step from ACS to traceback
    typedef struct packed {
        logic               valid;
        decision_t          decision;
        logic [state_w-1:0] best;
    } step_t;

endpackage

//--- hw/bit_fifo.sv
module bit_fifo (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            clear,
    input  logic                            push,
    input  logic                            push_bit,
    input  logic                            pop,
    output logic                            pop_bit,
    output logic [viterbi_pkg::count_w-1:0] count,
    output logic                            full
);
    import viterbi_pkg::*;

    logic [fifo_depth-1:0] bits;
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (count == count_w'(fifo_depth));
    assign do_push = push && !full;
    assign do_pop  = pop && (count != '0);
    // Head of the queue, valid whenever count is nonzero
    assign pop_bit = bits[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            bits[wr_ptr] <= push_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/viterbi_top.sv
module viterbi_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  viterbi_pkg::wb_req_t wb_req,
    output viterbi_pkg::wb_rsp_t wb_rsp
);
    import viterbi_pkg::*;

    logic               sym_valid;
    logic               sym_ready;
    sym_t               sym;
    logic               clear;
    logic               busy;
    step_t              step;
    logic               push;
    logic               push_bit;
    logic               pop;
    logic               pop_bit;
    logic               fifo_full;
    logic [count_w-1:0] fifo_count;

    // Host side
    wb_symbol_port u_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .sym_valid  (sym_valid),
        .sym        (sym),
        .sym_ready  (sym_ready),
        .clear      (clear),
        .pop        (pop),
        .fifo_bit   (pop_bit),
        .fifo_count (fifo_count),
        .busy       (busy)
    );

    ////////////////////
    // Decoder core
    ////////////////////

    acs_unit u_acs (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .sym_valid (sym_valid),
        .sym       (sym),
        .step      (step)
    );

    traceback_unit u_tb (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .step      (step),
        .fifo_full (fifo_full),
        .sym_ready (sym_ready),
        .busy      (busy),
        .push      (push),
        .push_bit  (push_bit)
    );

    // Decoded bits wait here for the host
    bit_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .push     (push),
        .push_bit (push_bit),
        .pop      (pop),
        .pop_bit  (pop_bit),
        .count    (fifo_count),
        .full     (fifo_full)
    );

endmodule

//--- hw/wb_symbol_port.sv
module wb_symbol_port (
    input  logic                            clk,
    input  logic                            rst_n,
    input  viterbi_pkg::wb_req_t            wb_req,
    output viterbi_pkg::wb_rsp_t            wb_rsp,
    output logic                            sym_valid,
    output viterbi_pkg::sym_t               sym,
    input  logic                            sym_ready,
    output logic                            clear,
    output logic                            pop,
    input  logic                            fifo_bit,
    input  logic [viterbi_pkg::count_w-1:0] fifo_count,
    input  logic                            busy
);
    import viterbi_pkg::*;

    logic                start;
    logic                sym_wr;
    logic                simple_acc;
    logic                fifo_valid;
    logic                ack_q;
    logic [wb_dat_w-1:0] rdata;
    logic [wb_dat_w-1:0] dat_q;

    // New access: strobe up and not yet acked
    assign start      = wb_req.cyc && wb_req.stb && !ack_q;
    assign sym_wr     = start && wb_req.we && (wb_req.adr == adr_symbol);
    // Everything except a symbol write finishes in one cycle
    assign simple_acc = start && !sym_wr;

    // Symbol write waits here until the core can take it
    assign sym_valid = sym_wr && sym_ready;
    assign sym       = wb_req.dat[1:0];

    assign fifo_valid = (fifo_count != '0);
    assign pop        = simple_acc && !wb_req.we && (wb_req.adr == adr_result) && fifo_valid;

    ////////////////////
    // Read data
    ////////////////////

    always_comb begin
        rdata = '0;
        if (!wb_req.we) begin
            case (wb_req.adr)
                adr_result: begin
                    // Empty FIFO reads as all zero
                    rdata[1] = fifo_valid;
                    rdata[0] = fifo_valid && fifo_bit;
                end
                adr_status: begin
                    rdata[count_w-1:0] = fifo_count;
                    rdata[wb_dat_w-1]  = busy;
                end
                default: begin
                    rdata = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            clear <= 1'b0;
        end else begin
            ack_q <= sym_valid || simple_acc;
            // Single pulse, lands in the ack cycle
            clear <= simple_acc && wb_req.we && (wb_req.adr == adr_clear);
        end
    end

    always_ff @(posedge clk) begin
        if (sym_valid || simple_acc) begin
            dat_q <= rdata;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

//--- run.sh
#!/bin/sh
# Build and run the Viterbi decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_viterbi \
    -f tb.f -o sim_viterbi
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_viterbi > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "No result found in sim.log"
    exit 1
fi
exit 0

//--- tb.f
+incdir+bench
common/viterbi_pkg.sv
hw/wb_symbol_port.sv
viterbi_core/acs_unit.sv
viterbi_core/traceback_unit.sv
hw/bit_fifo.sv
hw/viterbi_top.sv
bench/tb_viterbi.sv

//--- viterbi_core/acs_unit.sv
module acs_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               sym_valid,
    input  viterbi_pkg::sym_t  sym,
    output viterbi_pkg::step_t step
);
    import viterbi_pkg::*;

    metric_t            pm     [num_states];
    metric_t            pm_new [num_states];
    metric_t            pm_min;
    decision_t          dec;
    logic [state_w-1:0] best;
    logic               step_valid;
    decision_t          step_dec;
    logic [state_w-1:0] step_best;

    // Hamming distance between received symbol and branch label
    function automatic metric_t branch_dist(sym_t rx, sym_t label);
        sym_t diff;
        diff = rx ^ label;
        return metric_t'(diff[1]) + metric_t'(diff[0]);
    endfunction

    ////////////////////
    // Add-compare-select
    ////////////////////

    always_comb begin
        logic [state_w-1:0] nxt;
        logic [state_w-1:0] p0;
        logic [state_w-1:0] p1;
        metric_t            m0;
        metric_t            m1;
        for (int ns = 0; ns < num_states; ns++) begin
            nxt = state_w'(ns);
            // Predecessors share the old MSB as their LSB-shifted bit
            p0  = {nxt[0], 1'b0};
            p1  = {nxt[0], 1'b1};
            // Input bit that leads into nxt is its MSB
            m0  = pm[p0] + branch_dist(sym, branch_out[p0][nxt[1]]);
            m1  = pm[p1] + branch_dist(sym, branch_out[p1][nxt[1]]);
            // Tie keeps the lower predecessor
            dec[ns]    = (m1 < m0);
            pm_new[ns] = (m1 < m0) ? m1 : m0;
        end
    end

    // Lowest-index state holding the minimum
    always_comb begin
        pm_min = pm_new[0];
        best   = '0;
        for (int s = 1; s < num_states; s++) begin
            if (pm_new[s] < pm_min) begin
                pm_min = pm_new[s];
                best   = state_w'(s);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            for (int s = 0; s < num_states; s++) begin
                pm[s] <= (s == 0) ? '0 : metric_t'(init_metric);
            end
            step_valid <= 1'b0;
        end else begin
            step_valid <= sym_valid;
            if (sym_valid) begin
                // Normalize so the best path sits at zero
                for (int s = 0; s < num_states; s++) begin
                    pm[s] <= pm_new[s] - pm_min;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sym_valid) begin
            step_dec  <= dec;
            step_best <= best;
        end
    end

    assign step = '{valid: step_valid, decision: step_dec, best: step_best};

endmodule

//--- viterbi_core/traceback_unit.sv
module traceback_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  viterbi_pkg::step_t step,
    input  logic               fifo_full,
    output logic               sym_ready,
    output logic               busy,
    output logic               push,
    output logic               push_bit
);
    import viterbi_pkg::*;

    decision_t            surv_mem [mem_depth];
    logic [mem_ptr_w-1:0] wr_ptr;
    logic [mem_ptr_w-1:0] rd_ptr;
    logic [fill_w-1:0]    stored;
    logic                 walking;
    logic                 emit;
    logic [mem_ptr_w-1:0] walk_cnt;
    logic [state_w-1:0]   tb_state;
    logic [state_w-1:0]   prev_state;
    decision_t            rd_dec;
    logic                 last_step;

    ////////////////////
    // Survivor ring
    ////////////////////

    always_ff @(posedge clk) begin
        if (step.valid) begin
            surv_mem[wr_ptr] <= step.decision;
        end
    end

    // Decision bit picks which predecessor we came from
    assign rd_dec     = surv_mem[rd_ptr];
    assign prev_state = {tb_state[0], rd_dec[tb_state]};

    // Walk covers entries newest down to newest-(trace_depth-1)
    assign last_step = walking && (walk_cnt == mem_ptr_w'(trace_depth - 1));

    // One symbol in flight, held off also while the result is pushed
    assign busy      = step.valid || walking || push;
    assign sym_ready = !busy && !fifo_full;

    ////////////////////
    // Walk control
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            wr_ptr  <= '0;
            stored  <= '0;
            walking <= 1'b0;
            push    <= 1'b0;
        end else begin
            push <= last_step && emit;
            if (step.valid) begin
                wr_ptr  <= wr_ptr + 1'b1;
                walking <= 1'b1;
                // Saturates once the ring is deep enough
                if (stored != fill_w'(trace_depth + 1)) begin
                    stored <= stored + 1'b1;
                end
            end else if (last_step) begin
                walking <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step.valid) begin
            tb_state <= step.best;
            rd_ptr   <= wr_ptr;
            walk_cnt <= '0;
            // Output starts with symbol index trace_depth
            emit     <= (stored >= fill_w'(trace_depth));
        end else if (walking) begin
            tb_state <= prev_state;
            rd_ptr   <= rd_ptr - 1'b1;
            walk_cnt <= walk_cnt + 1'b1;
        end
        // MSB of the oldest state is that symbol's input bit
        if (last_step) begin
            push_bit <= prev_state[1];
        end
    end

endmodule
